/* Makefile */
VERILATOR := verilator
VFLAGS := --binary --timing --assert -j 0
TOP := relspwedTb
FILELIST := build.f
OBJDIR := obj_dir
BIN := $(OBJDIR)/V$(TOP)
PASS_TEXT := Simulation completed successfully

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJDIR)

/* build.f */
+incdir+include
logic/lspQuantPkg.sv
logic/wbBus.sv
logic/busArbiter.sv
logic/lspCombiner.sv
logic/lspCodePacker.sv
logic/relspwedTop.sv
test/wbMemoryModel.sv
test/relspwedTb.sv

/* include/lspQuant_params.svh */
`ifndef LSP_QUANT_PARAMS_SVH
`define LSP_QUANT_PARAMS_SVH

// bus widths
`define LSP_ADDR_W 12
`define LSP_DATA_W 16

// codebook shape
`define LSP_M 10
`define LSP_NC 5          // lower half uses the first index
`define LSP_MODES 2
`define LSP_NC0_B 7
`define LSP_NC1_B 5
`define LSP_ROW_STRIDE 16

//////////////////////////////////////////////////////////////////////
// memory map, word addresses
//////////////////////////////////////////////////////////////////////

`define LSP_CB1_BASE 12'h000     // 128 rows
`define LSP_CB2_BASE 12'h800     // 32 rows
`define LSP_CAND_BASE 12'hA00
`define LSP_TINDEX1_BASE 12'hA02
`define LSP_TINDEX2_BASE 12'hA04
`define LSP_MODE_ADDR 12'hA06    // mode in bit 0
`define LSP_BUF_BASE 12'hA10     // one row per mode
`define LSP_CODE_BASE 12'hA30

`endif

/* logic/busArbiter.sv */
module busArbiter
(
	input logic clk,
	input logic reset,
	wbBus.slave masterA,
	wbBus.slave masterB,
	output logic cyc,
	output logic stb,
	output logic we,
	output lspQuantPkg::busAddr adr,
	output lspQuantPkg::lspWord datW,
	input lspQuantPkg::lspWord datR,
	input logic ack
);

	logic granted;     // some master owns the bus
	logic grantB;      // owner is masterB
	logic priorityB;   // masterB wins the next tie
	logic ownerCyc;

	assign ownerCyc = grantB ? masterB.cyc : masterA.cyc;

	//////////////////////////////////////////////////////////////////////
	// grant
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			granted <= 1'b0;
			grantB <= 1'b0;
			priorityB <= 1'b0;
		end
		else if (granted)
		begin
			// owner let go, the other side goes first next time
			if (!ownerCyc)
			begin
				granted <= 1'b0;
				priorityB <= !grantB;
			end
		end
		else if (masterA.cyc || masterB.cyc)
		begin
			granted <= 1'b1;
			grantB <= masterB.cyc && (!masterA.cyc || priorityB);
		end
	end

	// shared port follows the owner
	assign cyc = granted && ownerCyc;
	assign stb = granted && (grantB ? masterB.stb : masterA.stb);
	assign we = granted && (grantB ? masterB.we : masterA.we);
	assign adr = grantB ? masterB.adr : masterA.adr;
	assign datW = grantB ? masterB.datW : masterA.datW;

	// responses only to the owner
	assign masterA.ack = granted && !grantB && ack;
	assign masterB.ack = granted && grantB && ack;
	assign masterA.datR = (granted && !grantB) ? datR : '0;
	assign masterB.datR = (granted && grantB) ? datR : '0;

endmodule

/* logic/lspCodePacker.sv */
`include "lspQuant_params.svh"

module lspCodePacker
(
	input logic clk,
	input logic reset,
	input logic go,
	output logic finished,
	wbBus.master bus
);
	import lspQuantPkg::*;

	typedef enum logic [2:0]
	{
		stIdle,
		stRdMode,
		stRdCand,
		stRdIdx1,
		stRdIdx2,
		stWrCode0,
		stWrCode1
	} packState;

	packState state;
	logic reqCyc;
	modeSel mode;      // chosen mode as read back
	cand1Index cand;
	cand2Index idx1;
	cand2Index idx2;
	lspWord code0;
	lspWord code1;

	// transmitted words
	assign code0 = (lspWord'(mode) << `LSP_NC0_B) | lspWord'(cand);
	assign code1 = (lspWord'(idx1) << `LSP_NC1_B) | lspWord'(idx2);

	assign bus.cyc = reqCyc;
	assign bus.stb = reqCyc;
	assign bus.we = (state == stWrCode0) || (state == stWrCode1);
	assign bus.datW = (state == stWrCode1) ? code1 : code0;

	always_comb
	begin
		case (state)
			stRdMode: bus.adr = `LSP_MODE_ADDR;
			stRdCand: bus.adr = `LSP_CAND_BASE + busAddr'(mode);
			stRdIdx1: bus.adr = `LSP_TINDEX1_BASE + busAddr'(mode);
			stRdIdx2: bus.adr = `LSP_TINDEX2_BASE + busAddr'(mode);
			stWrCode1: bus.adr = `LSP_CODE_BASE + busAddr'(1);
			default: bus.adr = `LSP_CODE_BASE;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// sequencing
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= stIdle;
			reqCyc <= 1'b0;
			finished <= 1'b0;
		end
		else
		begin
			finished <= 1'b0;
			if (state == stIdle)
			begin
				if (go)
					state <= stRdMode;
			end
			else if (!reqCyc)
				reqCyc <= 1'b1;
			else if (bus.ack)
			begin
				reqCyc <= 1'b0;
				case (state)
					stRdMode: state <= stRdCand;
					stRdCand: state <= stRdIdx1;
					stRdIdx1: state <= stRdIdx2;
					stRdIdx2: state <= stWrCode0;
					stWrCode0: state <= stWrCode1;
					default:
					begin
						state <= stIdle;
						finished <= 1'b1;   // second code word written
					end
				endcase
			end
		end
	end

	// fields masked to their widths on capture
	always_ff @(posedge clk)
	begin
		if (reqCyc && bus.ack)
		begin
			case (state)
				stRdMode: mode <= bus.datR[0];
				stRdCand: cand <= bus.datR[`LSP_NC0_B-1:0];
				stRdIdx1: idx1 <= bus.datR[`LSP_NC1_B-1:0];
				stRdIdx2: idx2 <= bus.datR[`LSP_NC1_B-1:0];
				default: ;
			endcase
		end
	end

endmodule

/* logic/lspCombiner.sv */
`include "lspQuant_params.svh"

module lspCombiner
(
	input logic clk,
	input logic reset,
	input logic go,
	output logic finished,
	wbBus.master bus
);
	import lspQuantPkg::*;

	localparam int jWidth = $clog2(`LSP_M);
	localparam lspWord wordMax = {1'b0, {(`LSP_DATA_W-1){1'b1}}};
	localparam lspWord wordMin = {1'b1, {(`LSP_DATA_W-1){1'b0}}};

	typedef enum logic [2:0]
	{
		stIdle,
		stRdCand,
		stRdIdx1,
		stRdIdx2,
		stRdCb1,
		stRdCb2,
		stWrBuf
	} combState;

	combState state;
	modeSel mode;
	logic [jWidth-1:0] j;
	logic reqCyc;       // access in flight
	cand1Index cand;
	cand2Index idx1;
	cand2Index idx2;
	lspWord acc;        // cb1 entry, then the clipped sum
	logic upperHalf;

	function automatic lspWord satAdd(lspWord a, lspWord b);
		logic [`LSP_DATA_W:0] wide;
		wide = {a[`LSP_DATA_W-1], a} + {b[`LSP_DATA_W-1], b};
		if (wide[`LSP_DATA_W] != wide[`LSP_DATA_W-1])
			return wide[`LSP_DATA_W] ? wordMin : wordMax;
		return wide[`LSP_DATA_W-1:0];
	endfunction

	function automatic busAddr rowAddr(busAddr base, int row, int col);
		return busAddr'(int'(base) + row * `LSP_ROW_STRIDE + col);
	endfunction

	assign upperHalf = (j >= `LSP_NC);

	//////////////////////////////////////////////////////////////////////
	// bus side
	//////////////////////////////////////////////////////////////////////

	assign bus.cyc = reqCyc;
	assign bus.stb = reqCyc;
	assign bus.we = (state == stWrBuf);
	assign bus.datW = acc;

	always_comb
	begin
		case (state)
			stRdCand: bus.adr = `LSP_CAND_BASE + busAddr'(mode);
			stRdIdx1: bus.adr = `LSP_TINDEX1_BASE + busAddr'(mode);
			stRdIdx2: bus.adr = `LSP_TINDEX2_BASE + busAddr'(mode);
			stRdCb1: bus.adr = rowAddr(`LSP_CB1_BASE, int'(cand), int'(j));
			stRdCb2: bus.adr = rowAddr(`LSP_CB2_BASE, int'(upperHalf ? idx2 : idx1), int'(j));
			stWrBuf: bus.adr = rowAddr(`LSP_BUF_BASE, int'(mode), int'(j));
			default: bus.adr = `LSP_CAND_BASE;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// sequencing, one access per state
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= stIdle;
			reqCyc <= 1'b0;
			mode <= '0;
			j <= '0;
			finished <= 1'b0;
		end
		else
		begin
			finished <= 1'b0;
			if (state == stIdle)
			begin
				if (go)
				begin
					state <= stRdCand;
					mode <= '0;
					j <= '0;
				end
			end
			else if (!reqCyc)
				reqCyc <= 1'b1;   // cyc was low for a cycle, issue
			else if (bus.ack)
			begin
				reqCyc <= 1'b0;
				case (state)
					stRdCand: state <= stRdIdx1;
					stRdIdx1: state <= stRdIdx2;
					stRdIdx2: state <= stRdCb1;
					stRdCb1: state <= stRdCb2;
					stRdCb2: state <= stWrBuf;
					stWrBuf:
					begin
						if (j == jWidth'(`LSP_M - 1))
						begin
							j <= '0;
							if (mode == modeSel'(`LSP_MODES - 1))
							begin
								state <= stIdle;
								finished <= 1'b1;
							end
							else
							begin
								mode <= mode + 1'b1;
								state <= stRdCand;
							end
						end
						else
						begin
							j <= j + 1'b1;
							state <= stRdCb1;
						end
					end
					default: state <= stIdle;
				endcase
			end
		end
	end

	// read data capture
	always_ff @(posedge clk)
	begin
		if (reqCyc && bus.ack)
		begin
			case (state)
				stRdCand: cand <= bus.datR[`LSP_NC0_B-1:0];
				stRdIdx1: idx1 <= bus.datR[`LSP_NC1_B-1:0];
				stRdIdx2: idx2 <= bus.datR[`LSP_NC1_B-1:0];
				stRdCb1: acc <= bus.datR;
				stRdCb2: acc <= satAdd(acc, bus.datR);
				default: ;
			endcase
		end
	end

endmodule

/* logic/lspQuantPkg.sv */
`include "lspQuant_params.svh"

package lspQuantPkg;

	// sample word, Q-format is the caller's business
	typedef logic signed [`LSP_DATA_W-1:0] lspWord;

	// word address into the shared data memory
	typedef logic [`LSP_ADDR_W-1:0] busAddr;

	//////////////////////////////////////////////////////////////////////
	// codebook indices
	//////////////////////////////////////////////////////////////////////

	// row of the first-stage codebook
	typedef logic [`LSP_NC0_B-1:0] cand1Index;

	// row of the second-stage codebook
	typedef logic [`LSP_NC1_B-1:0] cand2Index;

	// MA predictor mode
	typedef logic modeSel;

endpackage

/* logic/relspwedTop.sv */
module relspwedTop
(
	input logic clk,
	input logic reset,
	input logic start,
	output logic done,
	output logic wbCyc,
	output logic wbStb,
	output logic wbWe,
	output lspQuantPkg::busAddr wbAdr,
	output lspQuantPkg::lspWord wbDatW,
	input lspQuantPkg::lspWord wbDatR,
	input logic wbAck
);

	logic busy;
	logic go;
	logic combFinished;
	logic packFinished;
	logic combSeen;     // combiner finished earlier in this run
	logic packSeen;
	logic combDone;
	logic packDone;

	wbBus combBus();
	wbBus packBus();

	assign combDone = combSeen || combFinished;
	assign packDone = packSeen || packFinished;

	//////////////////////////////////////////////////////////////////////
	// run control
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			go <= 1'b0;
			done <= 1'b0;
			combSeen <= 1'b0;
			packSeen <= 1'b0;
		end
		else
		begin
			go <= 1'b0;
			done <= 1'b0;
			if (!busy)
			begin
				if (start)
				begin
					busy <= 1'b1;
					go <= 1'b1;
				end
			end
			else if (combDone && packDone)
			begin
				busy <= 1'b0;
				done <= 1'b1;
				combSeen <= 1'b0;
				packSeen <= 1'b0;
			end
			else
			begin
				combSeen <= combDone;
				packSeen <= packDone;
			end
		end
	end

	lspCombiner combiner
	(
		.clk(clk),
		.reset(reset),
		.go(go),
		.finished(combFinished),
		.bus(combBus)
	);

	lspCodePacker packer
	(
		.clk(clk),
		.reset(reset),
		.go(go),
		.finished(packFinished),
		.bus(packBus)
	);

	// combiner on port A, packer on port B
	busArbiter arbiter
	(
		.clk(clk),
		.reset(reset),
		.masterA(combBus),
		.masterB(packBus),
		.cyc(wbCyc),
		.stb(wbStb),
		.we(wbWe),
		.adr(wbAdr),
		.datW(wbDatW),
		.datR(wbDatR),
		.ack(wbAck)
	);

endmodule

/* logic/wbBus.sv */
interface wbBus;
	import lspQuantPkg::*;

	logic cyc;
	logic stb;
	logic we;
	busAddr adr;
	lspWord datW;
	lspWord datR;   // valid in the ack cycle
	logic ack;

	modport master
	(
		output cyc,
		output stb,
		output we,
		output adr,
		output datW,
		input datR,
		input ack
	);

	modport slave
	(
		input cyc,
		input stb,
		input we,
		input adr,
		input datW,
		output datR,
		output ack
	);

endinterface

/* test/relspwedTb.sv */
`include "lspQuant_params.svh"

module relspwedTb;
	timeunit 1ns;
	timeprecision 1ps;
	import lspQuantPkg::*;

	localparam int clkPeriod = 40;
	localparam int driveDelay = 2;
	localparam int unsigned seed = 65;
	localparam int doneTimeout = 5000;
	localparam int drainCycles = 60;
	localparam int writesPerRun = 2 * `LSP_M + 2;
	localparam int cb1Rows = 1 << `LSP_NC0_B;
	localparam int cb2Rows = 1 << `LSP_NC1_B;
	localparam int nc0Mask = cb1Rows - 1;
	localparam int nc1Mask = cb2Rows - 1;

	logic clk;
	logic reset;
	logic start;
	logic done;
	logic wbCyc;
	logic wbStb;
	logic wbWe;
	busAddr wbAdr;
	lspWord wbDatW;
	lspWord wbDatR;
	logic wbAck;
	logic loadEn;
	busAddr loadAdr;
	lspWord loadDat;

	lspWord image [0:(1 << `LSP_ADDR_W) - 1];   // expected memory contents
	logic [31:0] rngState;
	logic started;
	int doneCount;
	logic pending;      // request seen without ack
	busAddr heldAdr;
	logic heldWe;
	lspWord heldDatW;

	relspwedTop dut
	(
		.clk(clk),
		.reset(reset),
		.start(start),
		.done(done),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbWe(wbWe),
		.wbAdr(wbAdr),
		.wbDatW(wbDatW),
		.wbDatR(wbDatR),
		.wbAck(wbAck)
	);

	wbMemoryModel #(.seed(seed)) mem
	(
		.clk(clk),
		.reset(reset),
		.cyc(wbCyc),
		.stb(wbStb),
		.we(wbWe),
		.adr(wbAdr),
		.datW(wbDatW),
		.datR(wbDatR),
		.ack(wbAck),
		.loadEn(loadEn),
		.loadAdr(loadAdr),
		.loadDat(loadDat)
	);

	initial
	begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// failure reporting
	//////////////////////////////////////////////////////////////////////

	task automatic stopRun();
		$display("Simulation failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic reportMismatch(string name, logic [31:0] got, logic [31:0] expected);
		$display("ERROR at %0t: %s is %h, expected %h", $time, name, got, expected);
		stopRun();
	endtask

	task automatic reportFailure(string what);
		$display("ERROR at %0t: %s", $time, what);
		stopRun();
	endtask

	function automatic logic [31:0] xorshift(logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	function automatic lspWord randomWord();
		rngState = xorshift(rngState);
		return lspWord'(rngState[15:0]);
	endfunction

	function automatic busAddr wordAddr(busAddr base, int row, int col);
		return base + busAddr'(row * `LSP_ROW_STRIDE + col);
	endfunction

	//////////////////////////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////////////////////////

	function automatic lspWord expectedBuf(int m, int j);
		int cand;
		int row2;
		int sum;
		cand = int'(image[busAddr'(`LSP_CAND_BASE + m)]) & nc0Mask;
		if (j < `LSP_NC)
			row2 = int'(image[busAddr'(`LSP_TINDEX1_BASE + m)]) & nc1Mask;
		else
			row2 = int'(image[busAddr'(`LSP_TINDEX2_BASE + m)]) & nc1Mask;
		sum = int'(image[wordAddr(`LSP_CB1_BASE, cand, j)])
			+ int'(image[wordAddr(`LSP_CB2_BASE, row2, j)]);
		if (sum > 32767)
			return lspWord'(32767);
		if (sum < -32768)
			return lspWord'(-32768);
		return lspWord'(sum);
	endfunction

	function automatic lspWord expectedCode(int k);
		int m;
		int cand;
		int idx1;
		int idx2;
		m = int'(image[`LSP_MODE_ADDR]) & 1;
		cand = int'(image[busAddr'(`LSP_CAND_BASE + m)]) & nc0Mask;
		idx1 = int'(image[busAddr'(`LSP_TINDEX1_BASE + m)]) & nc1Mask;
		idx2 = int'(image[busAddr'(`LSP_TINDEX2_BASE + m)]) & nc1Mask;
		if (k == 0)
			return lspWord'((m << `LSP_NC0_B) | cand);
		return lspWord'((idx1 << `LSP_NC1_B) | idx2);
	endfunction

	task automatic buildImage();
		int c0;
		int c1;
		int i10;
		int i21;
		for (int row = 0; row < cb1Rows; row++)
			for (int col = 0; col < `LSP_M; col++)
				image[wordAddr(`LSP_CB1_BASE, row, col)] = randomWord() >>> 2;
		for (int row = 0; row < cb2Rows; row++)
			for (int col = 0; col < `LSP_M; col++)
				image[wordAddr(`LSP_CB2_BASE, row, col)] = randomWord() >>> 2;
		for (int m = 0; m < `LSP_MODES; m++)
		begin
			image[busAddr'(`LSP_CAND_BASE + m)] = randomWord();   // upper bits are junk
			image[busAddr'(`LSP_TINDEX1_BASE + m)] = randomWord();
			image[busAddr'(`LSP_TINDEX2_BASE + m)] = randomWord();
		end
		c0 = int'(image[`LSP_CAND_BASE]) & nc0Mask;
		c1 = int'(image[busAddr'(`LSP_CAND_BASE + 1)]) & nc0Mask;
		i10 = int'(image[`LSP_TINDEX1_BASE]) & nc1Mask;
		i21 = int'(image[busAddr'(`LSP_TINDEX2_BASE + 1)]) & nc1Mask;
		// near the limits, mode 0 clips high and mode 1 clips low
		for (int col = 0; col < `LSP_NC; col++)
		begin
			image[wordAddr(`LSP_CB1_BASE, c0, col)] = lspWord'(16'h7000 + col);
			image[wordAddr(`LSP_CB2_BASE, i10, col)] = lspWord'(16'h6000 + col);
		end
		for (int col = `LSP_NC; col < `LSP_M; col++)
		begin
			image[wordAddr(`LSP_CB1_BASE, c1, col)] = lspWord'(16'h9000 - col);
			image[wordAddr(`LSP_CB2_BASE, i21, col)] = lspWord'(16'hA000 - col);
		end
	endtask

	task automatic loadWord(busAddr a);
		loadEn = 1'b1;
		loadAdr = a;
		loadDat = image[a];
		@(posedge clk);
		#driveDelay;
	endtask

	task automatic pushImage();
		for (int row = 0; row < cb1Rows; row++)
			for (int col = 0; col < `LSP_M; col++)
				loadWord(wordAddr(`LSP_CB1_BASE, row, col));
		for (int row = 0; row < cb2Rows; row++)
			for (int col = 0; col < `LSP_M; col++)
				loadWord(wordAddr(`LSP_CB2_BASE, row, col));
		for (int a = `LSP_CAND_BASE; a < `LSP_TINDEX2_BASE + `LSP_MODES; a++)
			loadWord(busAddr'(a));
		loadEn = 1'b0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// one run per chosen mode
	//////////////////////////////////////////////////////////////////////

	task automatic runOnce(logic modeBit);
		lspWord modeWord;
		int writesBefore;
		int donesBefore;
		int waited;
		logic codeSeen;     // packer's last write acknowledged
		logic busyStart;
		busAddr a;
		lspWord exp;
		for (int s = `LSP_BUF_BASE; s < `LSP_CODE_BASE + 2; s++)
		begin
			image[busAddr'(s)] = randomWord();   // junk where results land
			loadWord(busAddr'(s));
		end
		modeWord = randomWord();
		modeWord[0] = modeBit;
		image[`LSP_MODE_ADDR] = modeWord;
		loadWord(`LSP_MODE_ADDR);
		loadEn = 1'b0;
		writesBefore = mem.writeCount;
		donesBefore = doneCount;
		codeSeen = 1'b0;
		busyStart = 1'b0;
		started = 1'b1;
		start = 1'b1;
		@(posedge clk);
		#driveDelay;
		start = 1'b0;
		waited = 0;
		while (!done)
		begin
			if (waited == doneTimeout)
				reportFailure("timeout waiting for done");
			@(posedge clk);
			#driveDelay;
			waited++;
			start = 1'b0;
			if (codeSeen && !busyStart && !done)
			begin
				start = 1'b1;   // packer idle, combiner still running
				busyStart = 1'b1;
			end
			if (wbAck && wbWe && wbAdr == busAddr'(`LSP_CODE_BASE + 1))
				codeSeen = 1'b1;
		end
		for (int i = 0; i < drainCycles; i++)
		begin
			@(posedge clk);
			#driveDelay;
			assert (!done && !wbCyc)
				else reportFailure("bus activity or done pulse after the run ended");
		end
		assert (mem.writeCount - writesBefore == writesPerRun)
			else reportMismatch("writeCount", mem.writeCount - writesBefore, writesPerRun);
		assert (doneCount - donesBefore == 1)
			else reportMismatch("doneCount", doneCount - donesBefore, 1);
		for (int m = 0; m < `LSP_MODES; m++)
			for (int j = 0; j < `LSP_M; j++)
			begin
				a = wordAddr(`LSP_BUF_BASE, m, j);
				exp = expectedBuf(m, j);
				assert (mem.store[a] === exp)
					else reportMismatch($sformatf("buf[%0d][%0d]", m, j),
						32'(mem.store[a]), 32'(exp));
			end
		for (int k = 0; k < 2; k++)
		begin
			a = busAddr'(`LSP_CODE_BASE + k);
			exp = expectedCode(k);
			assert (mem.store[a] === exp)
				else reportMismatch($sformatf("code[%0d]", k), 32'(mem.store[a]), 32'(exp));
		end
	endtask

	// bus protocol watch
	always @(posedge clk)
	begin
		if (reset)
		begin
			pending <= 1'b0;
			doneCount <= 0;
		end
		else
		begin
			assert (!wbStb || wbCyc) else reportFailure("wbStb high while wbCyc low");
			if (!started)
				assert (!wbCyc && !wbStb && !wbWe && !done)
					else reportFailure("bus or done active before the first start");
			if (pending)
			begin
				assert (wbCyc && wbStb) else reportFailure("request withdrawn before ack");
				assert (wbAdr == heldAdr)
					else reportMismatch("wbAdr", 32'(wbAdr), 32'(heldAdr));
				assert (wbWe == heldWe)
					else reportMismatch("wbWe", 32'(wbWe), 32'(heldWe));
				assert (wbDatW == heldDatW)
					else reportMismatch("wbDatW", 32'(wbDatW), 32'(heldDatW));
			end
			pending <= wbCyc && wbStb && !wbAck;
			heldAdr <= wbAdr;
			heldWe <= wbWe;
			heldDatW <= wbDatW;
			if (done)
				doneCount <= doneCount + 1;
		end
	end

	initial
	begin
		reset = 1'b1;
		start = 1'b0;
		loadEn = 1'b0;
		loadAdr = '0;
		loadDat = '0;
		started = 1'b0;
		rngState = seed;
		repeat (2) @(posedge clk);
		#driveDelay;
		reset = 1'b0;
		buildImage();
		pushImage();
		runOnce(1'b0);
		runOnce(1'b1);
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

/* test/wbMemoryModel.sv */
`include "lspQuant_params.svh"

module wbMemoryModel
#(
	parameter int unsigned seed = 65
)
(
	input logic clk,
	input logic reset,
	input logic cyc,
	input logic stb,
	input logic we,
	input lspQuantPkg::busAddr adr,
	input lspQuantPkg::lspWord datW,
	output lspQuantPkg::lspWord datR,
	output logic ack,
	input logic loadEn,
	input lspQuantPkg::busAddr loadAdr,
	input lspQuantPkg::lspWord loadDat
);
	timeunit 1ns;
	timeprecision 1ps;
	import lspQuantPkg::*;

	lspWord store [0:(1 << `LSP_ADDR_W) - 1];
	int writeCount;
	logic [31:0] rngState;
	logic [1:0] waitLeft;
	logic armed;              // delay already drawn for this request
	logic ackReg = 1'b0;
	lspWord datReg = '0;

	assign ack = ackReg;
	assign datR = datReg;

	function automatic logic [31:0] xorshift(logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	always @(posedge clk)
	begin : access
		logic [31:0] nextState;
		nextState = xorshift(rngState);
		if (loadEn)
			store[loadAdr] <= loadDat;   // preload port
		if (reset)
		begin
			ackReg <= 1'b0;
			armed <= 1'b0;
			waitLeft <= '0;
			rngState <= seed;
			writeCount <= 0;
		end
		else if (ackReg)
			ackReg <= 1'b0;   // one pulse per transfer
		else if (cyc && stb)
		begin
			if (!armed)
				rngState <= nextState;
			if (!armed && nextState[1:0] != 2'd0)
			begin
				armed <= 1'b1;
				waitLeft <= nextState[1:0] - 2'd1;
			end
			else if (armed && waitLeft != 2'd0)
				waitLeft <= waitLeft - 2'd1;
			else
			begin
				armed <= 1'b0;
				ackReg <= 1'b1;
				datReg <= store[adr];
				if (we)
				begin
					store[adr] <= datW;
					writeCount <= writeCount + 1;
				end
			end
		end
	end

endmodule
